// ==== verilog.f ====
verilog/sd_card_pkg.sv
verilog/sd_crc16.sv
verilog/sd_cmd_decoder.sv
verilog/sd_blk_read.sv
verilog/sd_blk_write.sv
verilog/sd_mem_arbiter.sv
verilog/sd_card.sv
testbench/tb_sd_card.sv

// ==== run.sh ====
#!/bin/sh
# build and run the testbench with Verilator, the sim log decides the result
rm -rf obj_dir build.log sim.log
verilator --binary --timing -Wno-fatal -f verilog.f --top-module tb_sd_card \
    -o tb_sd_card > build.log 2>&1 || { cat build.log; exit 1; }
./obj_dir/tb_sd_card > sim.log 2>&1
cat sim.log
grep -q "test failed" sim.log && exit 1
grep -q "test passed" sim.log || exit 1
exit 0

// ==== testbench/tb_sd_card.sv ====
`timescale 1ns/1ns

module tb_sd_card;

    localparam int BLK_LEN = 16;

    logic sd_clk;
    logic rstn;
    logic cmd_i;
    logic dat_i;
    logic dat_o;
    logic dat_oe_o;

    sd_card_pkg::byte_t model_mem [2**sd_card_pkg::MEM_ADDR_W];
    logic [31:0]        rng_state;
    int                 wd_cycles;
    int                 n_multi;

    sd_card i_sd_card (
        .sd_clk   (sd_clk),
        .rstn     (rstn),
        .cmd_i    (cmd_i),
        .dat_i    (dat_i),
        .dat_o    (dat_o),
        .dat_oe_o (dat_oe_o)
    );

    initial begin
        sd_clk = 1'b0;
        forever #10 sd_clk = ~sd_clk;
    end

    function automatic logic [31:0] next_rand();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    // ccitt crc16 of one block in the model memory, msb first
    function automatic sd_card_pkg::crc16_t crc16_of(input sd_card_pkg::mem_addr_t addr);
        sd_card_pkg::crc16_t    c;
        sd_card_pkg::mem_addr_t cur;
        logic                   fb;
        c   = '0;
        cur = addr;
        for (int i = 0; i < BLK_LEN; i++) begin
            for (int j = 7; j >= 0; j--) begin
                fb = model_mem[cur][j] ^ c[15];
                c  = c << 1;
                if (fb)
                    c = c ^ 16'h1021;
            end
            cur++;
        end
        return c;
    endfunction

    // ----------------------------------------------------------------------
    // checks
    // ----------------------------------------------------------------------
    task automatic end_with_failure(input string why);
        $display("%s", why);
        $display("test failed");
        $fatal(1);
    endtask

    task automatic check_byte(input string name, input sd_card_pkg::byte_t got,
                              input sd_card_pkg::byte_t exp);
        if (got !== exp)
            end_with_failure($sformatf("MISMATCH t=%0t %s got %h expected %h",
                                       $time, name, got, exp));
    endtask

    task automatic check_crc(input string name, input sd_card_pkg::crc16_t got,
                             input sd_card_pkg::crc16_t exp);
        if (got !== exp)
            end_with_failure($sformatf("MISMATCH t=%0t %s got %h expected %h",
                                       $time, name, got, exp));
    endtask

    task automatic check_sts(input string name, input sd_card_pkg::crc_sts_t got,
                             input sd_card_pkg::crc_sts_t exp);
        if (got !== exp)
            end_with_failure($sformatf("MISMATCH t=%0t %s got %b expected %b",
                                       $time, name, got, exp));
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp)
            end_with_failure($sformatf("MISMATCH t=%0t %s got %b expected %b",
                                       $time, name, got, exp));
    endtask

    // ----------------------------------------------------------------------
    // host side
    // ----------------------------------------------------------------------
    task automatic step();
        @(posedge sd_clk);
        #2;  // drive and sample off the edge
    endtask

    task automatic wait_for_oe(input string what);
        int n;
        n = 0;
        while (dat_oe_o !== 1'b1) begin
            step();
            n++;
            if (n > 200)
                end_with_failure($sformatf("no %s from the card within 200 cycles", what));
        end
    endtask

    task automatic expect_idle(input int cycles);
        repeat (cycles) begin
            check_bit("dat_oe_o", dat_oe_o, 1'b0);
            step();
        end
    endtask

    task automatic send_cmd(input sd_card_pkg::cmd_index_t idx,
                            input sd_card_pkg::cmd_arg_t arg);
        logic [47:0] frame;
        frame = {2'b01, idx, arg, 7'h00, 1'b1};  // crc7 left at zero
        for (int i = 47; i >= 0; i--) begin
            cmd_i = frame[i];
            step();
        end
        cmd_i = 1'b1;
        repeat (2) step();
    endtask

    // random block out, then token and busy back
    task automatic write_block(input sd_card_pkg::mem_addr_t addr, input bit bad_crc);
        sd_card_pkg::mem_addr_t cur;
        sd_card_pkg::byte_t     data;
        sd_card_pkg::crc16_t    crc;
        sd_card_pkg::crc_sts_t  sts;
        int                     busy;
        dat_i = 1'b1;
        repeat (2) step();
        dat_i = 1'b0;
        step();
        cur = addr;
        for (int i = 0; i < BLK_LEN; i++) begin
            data           = sd_card_pkg::byte_t'(next_rand());
            model_mem[cur] = data;  // stored even with a bad crc
            for (int j = 7; j >= 0; j--) begin
                dat_i = data[j];
                step();
            end
            cur++;
        end
        crc = crc16_of(addr);
        if (bad_crc)
            crc = crc ^ (16'h0001 << (next_rand() % 16));
        for (int j = 15; j >= 0; j--) begin
            dat_i = crc[j];
            step();
        end
        dat_i = 1'b1;  // end bit
        step();
        wait_for_oe("status token");
        check_bit("token start bit", dat_o, 1'b0);
        for (int j = 2; j >= 0; j--) begin
            step();
            sts[j] = dat_o;
        end
        check_sts("crc status", sts,
                  bad_crc ? sd_card_pkg::CRC_STS_ERR : sd_card_pkg::CRC_STS_OK);
        step();
        check_bit("token end bit", dat_o, 1'b1);
        step();
        busy = 0;
        while (dat_oe_o === 1'b1) begin
            check_bit("busy dat_o", dat_o, 1'b0);
            busy++;
            if (busy > 64)
                end_with_failure("card stayed busy for more than 64 cycles");
            step();
        end
        if (busy < sd_card_pkg::BUSY_CYCLES)
            end_with_failure($sformatf("busy period of %0d cycles is too short", busy));
    endtask

    task automatic read_block(input sd_card_pkg::mem_addr_t addr);
        sd_card_pkg::mem_addr_t cur;
        sd_card_pkg::byte_t     data;
        sd_card_pkg::crc16_t    crc;
        wait_for_oe("read start bit");
        check_bit("read start bit", dat_o, 1'b0);
        cur = addr;
        for (int i = 0; i < BLK_LEN; i++) begin
            for (int j = 7; j >= 0; j--) begin
                step();
                check_bit("dat_oe_o", dat_oe_o, 1'b1);
                data[j] = dat_o;
            end
            check_byte($sformatf("read byte %0d", i), data, model_mem[cur]);
            cur++;
        end
        for (int j = 15; j >= 0; j--) begin
            step();
            check_bit("dat_oe_o", dat_oe_o, 1'b1);
            crc[j] = dat_o;
        end
        check_crc("read crc", crc, crc16_of(addr));
        step();
        check_bit("read end bit", dat_o, 1'b1);
        step();  // first cycle after the frame
    endtask

    // ----------------------------------------------------------------------
    // test sequence
    // ----------------------------------------------------------------------
    initial begin
        sd_card_pkg::cmd_arg_t  arg1;
        sd_card_pkg::cmd_arg_t  arg3;
        sd_card_pkg::cmd_arg_t  arg4;
        sd_card_pkg::mem_addr_t blk_addr;
        rng_state = 32'hc609_fefb;
        rstn      = 1'b0;
        cmd_i     = 1'b1;
        dat_i     = 1'b1;
        n_multi   = 2 + int'(next_rand() % 3);
        // blocks moved by all tests, plus command frames
        wd_cycles = ((7 + 2 * n_multi) * (8 * BLK_LEN + 18) + 16 * 48) * 4 + 2000;
        repeat (4) @(posedge sd_clk);
        #2;
        rstn = 1'b1;

        expect_idle(8);
        send_cmd(sd_card_pkg::CMD_SET_BLOCKLEN, sd_card_pkg::cmd_arg_t'(BLK_LEN));
        expect_idle(8);
        arg1 = next_rand();  // upper bits wrap inside the card
        send_cmd(sd_card_pkg::CMD_WRITE_SINGLE, arg1);
        write_block(sd_card_pkg::mem_addr_t'(arg1), 1'b0);
        send_cmd(sd_card_pkg::CMD_READ_SINGLE, arg1);
        read_block(sd_card_pkg::mem_addr_t'(arg1));
        expect_idle(4);

        arg3 = next_rand();
        send_cmd(sd_card_pkg::CMD_WRITE_SINGLE, arg3);
        write_block(sd_card_pkg::mem_addr_t'(arg3), 1'b1);
        send_cmd(sd_card_pkg::CMD_READ_SINGLE, arg3);
        read_block(sd_card_pkg::mem_addr_t'(arg3));

        // counted multi block write and read back
        arg4 = next_rand();
        send_cmd(sd_card_pkg::CMD_SET_BLOCK_COUNT, sd_card_pkg::cmd_arg_t'(n_multi));
        send_cmd(sd_card_pkg::CMD_WRITE_MULTI, arg4);
        blk_addr = sd_card_pkg::mem_addr_t'(arg4);
        for (int b = 0; b < n_multi; b++) begin
            write_block(blk_addr, 1'b0);
            blk_addr = blk_addr + sd_card_pkg::mem_addr_t'(BLK_LEN);
        end
        send_cmd(sd_card_pkg::CMD_READ_MULTI, arg4);
        blk_addr = sd_card_pkg::mem_addr_t'(arg4);
        for (int b = 0; b < n_multi; b++) begin
            read_block(blk_addr);
            blk_addr = blk_addr + sd_card_pkg::mem_addr_t'(BLK_LEN);
        end
        expect_idle(8);

        // open ended stream, stopped by cmd12
        send_cmd(sd_card_pkg::CMD_SET_BLOCK_COUNT, '0);
        send_cmd(sd_card_pkg::CMD_READ_MULTI, arg4);
        read_block(sd_card_pkg::mem_addr_t'(arg4));
        read_block(sd_card_pkg::mem_addr_t'(arg4) + sd_card_pkg::mem_addr_t'(BLK_LEN));
        send_cmd(sd_card_pkg::CMD_STOP, '0);
        expect_idle(40);
        send_cmd(sd_card_pkg::CMD_READ_SINGLE, arg1);
        read_block(sd_card_pkg::mem_addr_t'(arg1));
        expect_idle(8);

        $display("test passed");
        $finish;
    end

    // watchdog
    initial begin
        wait (wd_cycles > 0);
        repeat (wd_cycles) @(posedge sd_clk);
        $display("watchdog expired after %0d cycles, the run is stuck", wd_cycles);
        $display("test failed");
        $fatal(1);
    end

endmodule

// ==== verilog/sd_card.sv ====
`timescale 1ns/1ns

module sd_card (
    input  logic sd_clk,
    input  logic rstn,
    input  logic cmd_i,
    input  logic dat_i,
    output logic dat_o,
    output logic dat_oe_o
);

    logic                   rd_start;
    logic                   wr_start;
    logic                   abort;
    sd_card_pkg::mem_addr_t start_addr;
    sd_card_pkg::blk_cnt_t  start_blk_cnt;
    sd_card_pkg::blk_len_t  blk_len;
    logic                   rd_busy;
    logic                   wr_busy;

    logic                   rd_mem_valid;
    logic                   rd_mem_ready;
    sd_card_pkg::mem_addr_t rd_mem_addr;
    sd_card_pkg::byte_t     rd_mem_rdata;
    logic                   wr_mem_valid;
    logic                   wr_mem_ready;
    sd_card_pkg::mem_addr_t wr_mem_addr;
    sd_card_pkg::byte_t     wr_mem_wdata;

    logic                   rd_dat;
    logic                   rd_dat_oe;
    logic                   wr_dat;
    logic                   wr_dat_oe;

    // read engine owns the line whenever it drives
    assign dat_o    = rd_dat_oe ? rd_dat : wr_dat;
    assign dat_oe_o = rd_dat_oe | wr_dat_oe;

    sd_cmd_decoder i_cmd_decoder (
        .sd_clk          (sd_clk),
        .rstn            (rstn),
        .cmd_i           (cmd_i),
        .rd_busy_i       (rd_busy),
        .wr_busy_i       (wr_busy),
        .rd_start_o      (rd_start),
        .wr_start_o      (wr_start),
        .abort_o         (abort),
        .start_addr_o    (start_addr),
        .start_blk_cnt_o (start_blk_cnt),
        .blk_len_o       (blk_len)
    );

    sd_blk_read i_blk_read (
        .sd_clk       (sd_clk),
        .rstn         (rstn),
        .start_i      (rd_start),
        .abort_i      (abort),
        .start_addr_i (start_addr),
        .blk_cnt_i    (start_blk_cnt),
        .blk_len_i    (blk_len),
        .mem_ready_i  (rd_mem_ready),
        .mem_rdata_i  (rd_mem_rdata),
        .mem_valid_o  (rd_mem_valid),
        .mem_addr_o   (rd_mem_addr),
        .busy_o       (rd_busy),
        .dat_o        (rd_dat),
        .dat_oe_o     (rd_dat_oe)
    );

    sd_blk_write i_blk_write (
        .sd_clk       (sd_clk),
        .rstn         (rstn),
        .start_i      (wr_start),
        .abort_i      (abort),
        .start_addr_i (start_addr),
        .blk_cnt_i    (start_blk_cnt),
        .blk_len_i    (blk_len),
        .dat_i        (dat_i),
        .mem_ready_i  (wr_mem_ready),
        .mem_valid_o  (wr_mem_valid),
        .mem_addr_o   (wr_mem_addr),
        .mem_wdata_o  (wr_mem_wdata),
        .busy_o       (wr_busy),
        .dat_o        (wr_dat),
        .dat_oe_o     (wr_dat_oe)
    );

    sd_mem_arbiter i_mem_arbiter (
        .sd_clk     (sd_clk),
        .rd_valid_i (rd_mem_valid),
        .rd_addr_i  (rd_mem_addr),
        .wr_valid_i (wr_mem_valid),
        .wr_addr_i  (wr_mem_addr),
        .wr_data_i  (wr_mem_wdata),
        .rd_ready_o (rd_mem_ready),
        .rd_data_o  (rd_mem_rdata),
        .wr_ready_o (wr_mem_ready)
    );

endmodule

// ==== verilog/sd_mem_arbiter.sv ====
`timescale 1ns/1ns

module sd_mem_arbiter (
    input  logic                   sd_clk,
    input  logic                   rd_valid_i,
    input  sd_card_pkg::mem_addr_t rd_addr_i,
    input  logic                   wr_valid_i,
    input  sd_card_pkg::mem_addr_t wr_addr_i,
    input  sd_card_pkg::byte_t     wr_data_i,
    output logic                   rd_ready_o,
    output sd_card_pkg::byte_t     rd_data_o,
    output logic                   wr_ready_o
);

    sd_card_pkg::byte_t mem [2**sd_card_pkg::MEM_ADDR_W];
    logic               wr_gnt;
    logic               rd_gnt;

    // fixed priority, write first
    assign wr_gnt = wr_valid_i;
    assign rd_gnt = rd_valid_i & ~wr_valid_i;

    assign wr_ready_o = wr_gnt;
    assign rd_ready_o = rd_gnt;

    always_ff @(posedge sd_clk) begin
        if (wr_gnt)
            mem[wr_addr_i] <= wr_data_i;
        if (rd_gnt)
            rd_data_o <= mem[rd_addr_i];  // valid the cycle after grant
    end

endmodule

// ==== verilog/sd_blk_write.sv ====
`timescale 1ns/1ns

module sd_blk_write (
    input  logic                   sd_clk,
    input  logic                   rstn,
    input  logic                   start_i,
    input  logic                   abort_i,
    input  sd_card_pkg::mem_addr_t start_addr_i,
    input  sd_card_pkg::blk_cnt_t  blk_cnt_i,
    input  sd_card_pkg::blk_len_t  blk_len_i,
    input  logic                   dat_i,
    input  logic                   mem_ready_i,
    output logic                   mem_valid_o,
    output sd_card_pkg::mem_addr_t mem_addr_o,
    output sd_card_pkg::byte_t     mem_wdata_o,
    output logic                   busy_o,
    output logic                   dat_o,
    output logic                   dat_oe_o
);

    typedef enum logic [2:0] {
        WR_IDLE,
        WR_START,
        WR_DATA,
        WR_CRC,
        WR_CRC_WAIT,
        WR_STS,
        WR_BUSY
    } wr_state_t;

    wr_state_t             state;
    logic [3:0]            cnt;
    sd_card_pkg::blk_len_t byte_cnt;
    sd_card_pkg::blk_cnt_t blk_rem;
    sd_card_pkg::byte_t    byte_sr;
    sd_card_pkg::crc16_t   crc;
    sd_card_pkg::crc_sts_t sts;
    logic                  crc_err;
    logic                  last_byte;

    assign last_byte = (byte_cnt == blk_len_i - 1'b1);
    assign sts       = crc_err ? sd_card_pkg::CRC_STS_ERR : sd_card_pkg::CRC_STS_OK;
    assign busy_o    = (state != WR_IDLE);
    assign dat_oe_o  = state inside {WR_STS, WR_BUSY};

    // token frame is 0, status msb first, 1; busy drives low
    always_comb begin
        dat_o = 1'b0;
        if (state == WR_STS) begin
            case (cnt)
                4'd0:    dat_o = 1'b0;
                4'd1:    dat_o = sts[2];
                4'd2:    dat_o = sts[1];
                4'd3:    dat_o = sts[0];
                default: dat_o = 1'b1;
            endcase
        end
    end

    // ----------------------------------------------------------------------
    // block receive and status
    // ----------------------------------------------------------------------
    always_ff @(posedge sd_clk or negedge rstn) begin
        if (!rstn) begin
            state       <= WR_IDLE;
            cnt         <= '0;
            byte_cnt    <= '0;
            blk_rem     <= '0;
            mem_addr_o  <= '0;
            mem_valid_o <= 1'b0;
            crc_err     <= 1'b0;
        end else if (abort_i) begin
            state       <= WR_IDLE;
            cnt         <= '0;
            mem_valid_o <= 1'b0;
        end else begin
            if (mem_valid_o && mem_ready_i) begin
                mem_valid_o <= 1'b0;
                mem_addr_o  <= mem_addr_o + 1'b1;
            end
            case (state)
                WR_IDLE: begin
                    if (start_i) begin
                        state      <= WR_START;
                        mem_addr_o <= start_addr_i;
                        blk_rem    <= blk_cnt_i;
                    end
                end
                WR_START: begin
                    cnt      <= '0;
                    byte_cnt <= '0;
                    crc_err  <= 1'b0;
                    if (!dat_i)
                        state <= WR_DATA;
                end
                WR_DATA: begin
                    cnt <= cnt + 1'b1;
                    if (cnt == 4'd7) begin
                        cnt         <= '0;
                        mem_valid_o <= 1'b1;  // post the finished byte
                        if (last_byte)
                            state <= WR_CRC;
                        else
                            byte_cnt <= byte_cnt + 1'b1;
                    end
                end
                WR_CRC: begin
                    cnt <= cnt + 1'b1;
                    if (dat_i != crc[4'd15 - cnt])
                        crc_err <= 1'b1;
                    if (cnt == 4'd15)
                        state <= WR_CRC_WAIT;
                end
                WR_CRC_WAIT: begin  // end bit, then the turnaround
                    cnt <= cnt + 1'b1;
                    if (cnt == 4'(sd_card_pkg::CRC_WAIT_CYCLES)) begin
                        state <= WR_STS;
                        cnt   <= '0;
                    end
                end
                WR_STS: begin
                    cnt <= cnt + 1'b1;
                    if (cnt == 4'd4) begin
                        state <= WR_BUSY;
                        cnt   <= '0;
                    end
                end
                WR_BUSY: begin
                    cnt <= cnt + 1'b1;
                    if (cnt == 4'(sd_card_pkg::BUSY_CYCLES - 1)) begin
                        cnt <= '0;
                        if (blk_rem != '0)
                            blk_rem <= blk_rem - 1'b1;
                        state <= (blk_rem == 16'd1) ? WR_IDLE : WR_START;
                    end
                end
                default: state <= WR_IDLE;
            endcase
        end
    end

    always_ff @(posedge sd_clk) begin
        if (state == WR_DATA)
            byte_sr <= {byte_sr[6:0], dat_i};
        if (state == WR_DATA && cnt == 4'd7)
            mem_wdata_o <= {byte_sr[6:0], dat_i};
    end

    sd_crc16 i_crc16 (
        .sd_clk  (sd_clk),
        .rstn    (rstn),
        .clear_i (state == WR_START),
        .en_i    (state == WR_DATA),
        .bit_i   (dat_i),
        .crc_o   (crc)
    );

endmodule

// ==== verilog/sd_blk_read.sv ====
`timescale 1ns/1ns

module sd_blk_read (
    input  logic                   sd_clk,
    input  logic                   rstn,
    input  logic                   start_i,
    input  logic                   abort_i,
    input  sd_card_pkg::mem_addr_t start_addr_i,
    input  sd_card_pkg::blk_cnt_t  blk_cnt_i,
    input  sd_card_pkg::blk_len_t  blk_len_i,
    input  logic                   mem_ready_i,
    input  sd_card_pkg::byte_t     mem_rdata_i,
    output logic                   mem_valid_o,
    output sd_card_pkg::mem_addr_t mem_addr_o,
    output logic                   busy_o,
    output logic                   dat_o,
    output logic                   dat_oe_o
);

    typedef enum logic [2:0] {
        RD_IDLE,
        RD_WAIT,
        RD_START,
        RD_DATA,
        RD_CRC,
        RD_END
    } rd_state_t;

    rd_state_t             state;
    logic [3:0]            cnt;       // wait, data bit and crc bit count
    sd_card_pkg::blk_len_t byte_cnt;
    sd_card_pkg::blk_cnt_t blk_rem;   // stays zero when open ended
    sd_card_pkg::byte_t    shift;
    sd_card_pkg::crc16_t   crc;
    logic                  mem_ack;
    logic                  last_byte;
    logic                  stall;

    assign last_byte = (byte_cnt == blk_len_i - 1'b1);

    // first byte in the last wait cycle, the others one bit early
    assign mem_valid_o = (state == RD_WAIT && cnt == 4'(sd_card_pkg::RD_WAIT_CYCLES - 2)) ||
                         (state == RD_DATA && cnt == 4'd6 && !last_byte);
    assign stall    = mem_valid_o & ~mem_ready_i;
    assign busy_o   = (state != RD_IDLE);
    assign dat_oe_o = state inside {RD_START, RD_DATA, RD_CRC, RD_END};

    always_comb begin
        case (state)
            RD_DATA: dat_o = shift[7];
            RD_CRC:  dat_o = crc[4'd15 - cnt];
            RD_END:  dat_o = 1'b1;
            default: dat_o = 1'b0;  // start bit
        endcase
    end

    always_ff @(posedge sd_clk or negedge rstn) begin
        if (!rstn) begin
            state      <= RD_IDLE;
            cnt        <= '0;
            byte_cnt   <= '0;
            blk_rem    <= '0;
            mem_addr_o <= '0;
            mem_ack    <= 1'b0;
        end else if (abort_i) begin
            state   <= RD_IDLE;
            cnt     <= '0;
            mem_ack <= 1'b0;
        end else begin
            mem_ack <= mem_valid_o & mem_ready_i;
            if (mem_valid_o && mem_ready_i)
                mem_addr_o <= mem_addr_o + 1'b1;
            case (state)
                RD_IDLE: begin
                    if (start_i) begin
                        state      <= RD_WAIT;
                        cnt        <= '0;
                        mem_addr_o <= start_addr_i;
                        blk_rem    <= blk_cnt_i;
                    end
                end
                RD_WAIT: begin
                    if (!stall) begin
                        if (cnt == 4'(sd_card_pkg::RD_WAIT_CYCLES - 2)) begin
                            state <= RD_START;
                            cnt   <= '0;
                        end else begin
                            cnt <= cnt + 1'b1;
                        end
                    end
                end
                RD_START: begin
                    state    <= RD_DATA;
                    byte_cnt <= '0;
                end
                RD_DATA: begin
                    if (!stall) begin
                        cnt <= cnt + 1'b1;
                        if (cnt == 4'd7) begin
                            cnt <= '0;
                            if (last_byte)
                                state <= RD_CRC;
                            else
                                byte_cnt <= byte_cnt + 1'b1;
                        end
                    end
                end
                RD_CRC: begin
                    cnt <= cnt + 1'b1;  // wraps to zero after bit 0
                    if (cnt == 4'd15)
                        state <= RD_END;
                end
                RD_END: begin
                    if (blk_rem != '0)
                        blk_rem <= blk_rem - 1'b1;
                    state <= (blk_rem == 16'd1) ? RD_IDLE : RD_WAIT;
                end
                default: state <= RD_IDLE;
            endcase
        end
    end

    always_ff @(posedge sd_clk) begin
        if (mem_ack)
            shift <= mem_rdata_i;
        else if (state == RD_DATA && !stall)
            shift <= {shift[6:0], 1'b0};
    end

    sd_crc16 i_crc16 (
        .sd_clk  (sd_clk),
        .rstn    (rstn),
        .clear_i (state == RD_START),
        .en_i    (state == RD_DATA && !stall),
        .bit_i   (shift[7]),
        .crc_o   (crc)
    );

endmodule

// ==== verilog/sd_cmd_decoder.sv ====
`timescale 1ns/1ns

module sd_cmd_decoder (
    input  logic                   sd_clk,
    input  logic                   rstn,
    input  logic                   cmd_i,
    input  logic                   rd_busy_i,
    input  logic                   wr_busy_i,
    output logic                   rd_start_o,
    output logic                   wr_start_o,
    output logic                   abort_o,
    output sd_card_pkg::mem_addr_t start_addr_o,
    output sd_card_pkg::blk_cnt_t  start_blk_cnt_o,
    output sd_card_pkg::blk_len_t  blk_len_o
);

    typedef enum logic [1:0] {
        DEC_IDLE,
        DEC_SHIFT,
        DEC_EXEC
    } dec_state_t;

    dec_state_t                       state;
    logic [5:0]                       bit_cnt;
    logic [sd_card_pkg::CMD_BITS-1:0] cmd_sr;  // trans, index, arg, crc7, end
    sd_card_pkg::cmd_index_t          cmd_index;
    sd_card_pkg::cmd_arg_t            cmd_arg;
    sd_card_pkg::blk_cnt_t            blk_cnt_q;
    logic                             engines_idle;

    assign cmd_index    = cmd_sr[45:40];
    assign cmd_arg      = cmd_sr[39:8];
    assign engines_idle = ~rd_busy_i & ~wr_busy_i;

    // ----------------------------------------------------------------------
    // frame capture
    // ----------------------------------------------------------------------
    always_ff @(posedge sd_clk or negedge rstn) begin
        if (!rstn) begin
            state   <= DEC_IDLE;
            bit_cnt <= '0;
        end else begin
            case (state)
                DEC_IDLE: begin
                    bit_cnt <= '0;
                    if (!cmd_i)
                        state <= DEC_SHIFT;  // start bit
                end
                DEC_SHIFT: begin
                    if (bit_cnt == 6'(sd_card_pkg::CMD_BITS - 1))
                        state <= DEC_EXEC;
                    else
                        bit_cnt <= bit_cnt + 1'b1;
                end
                default: state <= DEC_IDLE;
            endcase
        end
    end

    always_ff @(posedge sd_clk) begin
        if (state == DEC_SHIFT)
            cmd_sr <= {cmd_sr[sd_card_pkg::CMD_BITS-2:0], cmd_i};  // msb first
    end

    // ----------------------------------------------------------------------
    // command actions
    // ----------------------------------------------------------------------
    always_ff @(posedge sd_clk or negedge rstn) begin
        if (!rstn) begin
            rd_start_o <= 1'b0;
            wr_start_o <= 1'b0;
            abort_o    <= 1'b0;
            blk_len_o  <= sd_card_pkg::DEFAULT_BLK_LEN;
            blk_cnt_q  <= '0;
        end else begin
            rd_start_o <= 1'b0;
            wr_start_o <= 1'b0;
            abort_o    <= 1'b0;
            if (state == DEC_EXEC) begin
                case (cmd_index)
                    sd_card_pkg::CMD_GO_IDLE,
                    sd_card_pkg::CMD_STOP:            abort_o <= 1'b1;
                    sd_card_pkg::CMD_SET_BLOCKLEN:    blk_len_o <= sd_card_pkg::blk_len_t'(cmd_arg);
                    sd_card_pkg::CMD_SET_BLOCK_COUNT: blk_cnt_q <= sd_card_pkg::blk_cnt_t'(cmd_arg);
                    sd_card_pkg::CMD_READ_SINGLE,
                    sd_card_pkg::CMD_READ_MULTI:      rd_start_o <= engines_idle;
                    sd_card_pkg::CMD_WRITE_SINGLE,
                    sd_card_pkg::CMD_WRITE_MULTI:     wr_start_o <= engines_idle;
                    default: ;
                endcase
            end
        end
    end

    // qualified by the start pulses
    always_ff @(posedge sd_clk) begin
        if (state == DEC_EXEC) begin
            start_addr_o <= sd_card_pkg::mem_addr_t'(cmd_arg);
            if (cmd_index == sd_card_pkg::CMD_READ_MULTI ||
                cmd_index == sd_card_pkg::CMD_WRITE_MULTI)
                start_blk_cnt_o <= blk_cnt_q;
            else
                start_blk_cnt_o <= 16'd1;
        end
    end

endmodule

// ==== verilog/sd_crc16.sv ====
`timescale 1ns/1ns

module sd_crc16 (
    input  logic                sd_clk,
    input  logic                rstn,
    input  logic                clear_i,
    input  logic                en_i,
    input  logic                bit_i,
    output sd_card_pkg::crc16_t crc_o
);

    logic fb;

    assign fb = bit_i ^ crc_o[15];

    // x^16 + x^12 + x^5 + 1, zero seed
    always_ff @(posedge sd_clk or negedge rstn) begin
        if (!rstn) begin
            crc_o <= '0;
        end else if (clear_i) begin
            crc_o <= '0;
        end else if (en_i) begin
            crc_o <= {crc_o[14:0], 1'b0} ^ (fb ? 16'h1021 : 16'h0000);
        end
    end

endmodule

// ==== verilog/sd_card_pkg.sv ====
package sd_card_pkg;

    localparam int MEM_ADDR_W = 12;

    // ----------------------------------------------------------------------
    // widths with a meaning
    // ----------------------------------------------------------------------
    typedef logic [7:0]            byte_t;
    typedef logic [MEM_ADDR_W-1:0] mem_addr_t;   // 4 KiB, arguments wrap
    typedef logic [9:0]            blk_len_t;
    typedef logic [15:0]           blk_cnt_t;    // zero is open ended
    typedef logic [5:0]            cmd_index_t;
    typedef logic [31:0]           cmd_arg_t;
    typedef logic [15:0]           crc16_t;
    typedef logic [2:0]            crc_sts_t;

    localparam int CMD_BITS = 47;  // frame bits after the start bit

    // command indices
    localparam cmd_index_t CMD_GO_IDLE         = 6'd0;
    localparam cmd_index_t CMD_STOP            = 6'd12;
    localparam cmd_index_t CMD_SET_BLOCKLEN    = 6'd16;
    localparam cmd_index_t CMD_READ_SINGLE     = 6'd17;
    localparam cmd_index_t CMD_READ_MULTI      = 6'd18;
    localparam cmd_index_t CMD_SET_BLOCK_COUNT = 6'd23;
    localparam cmd_index_t CMD_WRITE_SINGLE    = 6'd24;
    localparam cmd_index_t CMD_WRITE_MULTI     = 6'd25;

    localparam blk_len_t DEFAULT_BLK_LEN = 10'd512;

    // ----------------------------------------------------------------------
    // card timing, in sd_clk cycles
    // ----------------------------------------------------------------------
    localparam int RD_WAIT_CYCLES  = 4;
    localparam int CRC_WAIT_CYCLES = 2;
    localparam int BUSY_CYCLES     = 8;

    // status tokens after a written block
    localparam crc_sts_t CRC_STS_OK  = 3'b010;
    localparam crc_sts_t CRC_STS_ERR = 3'b101;

endpackage
